/* source/lbdr_consts.svh */
// ------------------------------------------------
// mesh size, coordinate widths and lbdr bit counts
// for the 3d mesh routing stage
// ------------------------------------------------

`ifndef LBDR_CONSTS_SVH
`define LBDR_CONSTS_SVH

// mesh dimensions, numbered layer by layer, then row by row
`define LBDR_NUM_COLS 5
`define LBDR_NUM_ROWS 4
`define LBDR_NUM_LAYERS 3

// coordinate widths (x column, y row, z layer)
`define LBDR_X_W 3
`define LBDR_Y_W 2
`define LBDR_Z_W 2
`define LBDR_NODE_ID_W 6

// port count and table bit counts
`define LBDR_NUM_PORTS 6
`define LBDR_NUM_RBITS 24
`define LBDR_NUM_CBITS 6
`define LBDR_NUM_TBITS 6

`endif

/* source/noc_geom_pkg.sv */
// ------------------------------------------------
// mesh geometry types: node id, coordinate triple
// and relative direction flags
// ------------------------------------------------

`include "lbdr_consts.svh"

package noc_geom_pkg;

  // node number, layer * cols * rows + row * cols + col
  typedef logic [`LBDR_NODE_ID_W-1:0] node_id_t;

  // node position inside the mesh
  typedef struct packed {
    logic [`LBDR_X_W-1:0] x;
    logic [`LBDR_Y_W-1:0] y;
    logic [`LBDR_Z_W-1:0] z;
  } coord_t;

  // ------------------------------------------------
  // destination relative to the current node
  // a flag is set only when the destination lies
  // strictly that way on its axis
  // bit order matches the port mask, n is bit 5
  typedef struct packed {
    // y axis, larger row
    logic n;
    // x axis, larger column
    logic e;
    logic w;
    logic s;
    // z axis, upper layer
    logic u;
    logic d;
  } dir_flags_t;

endpackage

/* source/lbdr_pkg.sv */
// ------------------------------------------------
// lbdr types: port indices, port mask, routing
// bit indices and the configuration table
// ------------------------------------------------

`include "lbdr_consts.svh"

package lbdr_pkg;

  // port index inside a mask, order N-E-W-S-U-D from msb
  typedef enum logic [2:0] {
    PORT_D = 3'd0,
    PORT_U = 3'd1,
    PORT_S = 3'd2,
    PORT_W = 3'd3,
    PORT_E = 3'd4,
    PORT_N = 3'd5
  } port_e;

  // one candidate bit per output port
  typedef logic [`LBDR_NUM_PORTS-1:0] port_mask_t;

  // ------------------------------------------------
  // routing bit index, R_pq allows leaving through p
  // while the packet still has hops left toward q
  // straight-through bits are not part of the table
  typedef enum logic [4:0] {
    RDS = 5'd0,  RDN = 5'd1,  RDW = 5'd2,  RDE = 5'd3,
    RUS = 5'd4,  RUN = 5'd5,  RUW = 5'd6,  RUE = 5'd7,
    RSD = 5'd8,  RSU = 5'd9,  RSW = 5'd10, RSE = 5'd11,
    RWD = 5'd12, RWU = 5'd13, RWS = 5'd14, RWN = 5'd15,
    RED = 5'd16, REU = 5'd17, RES = 5'd18, REN = 5'd19,
    RND = 5'd20, RNU = 5'd21, RNW = 5'd22, RNE = 5'd23
  } rbit_e;

  // ------------------------------------------------
  // per-node table, quasi-static while traffic flows
  typedef struct packed {
    // routing bits, indexed by rbit_e
    logic [`LBDR_NUM_RBITS-1:0] r;
    // connectivity, indexed by port_e
    logic [`LBDR_NUM_CBITS-1:0] c;
    // turn bits, t_ab allows a turn from axis a into axis b
    struct packed {
      logic tyx;
      logic tzx;
      logic txy;
      logic tzy;
      logic txz;
      logic tyz;
    } t;
  } lbdr_cfg_t;

endpackage

/* source/lbdr_dest_decode.sv */
// ------------------------------------------------
// input side of the lbdr stage: splits the
// destination id into coordinates and registers
// the relative direction flags
// ------------------------------------------------

`timescale 1ns/100ps
`include "lbdr_consts.svh"

module lbdr_dest_decode
  import noc_geom_pkg::*;
#(
  parameter int unsigned NODE_ID = 0
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  // request from the producer
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  node_id_t   req_dest_i,
  // flags toward rule evaluation
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output dir_flags_t out_flags_o
);

  localparam int unsigned NODES_PER_LAYER = `LBDR_NUM_COLS * `LBDR_NUM_ROWS;

  // column, row within the layer, then layer
  function automatic coord_t id_to_coord(input node_id_t id);
    coord_t c;
    c.x = `LBDR_X_W'(id % `LBDR_NUM_COLS);
    c.y = `LBDR_Y_W'((id % NODES_PER_LAYER) / `LBDR_NUM_COLS);
    c.z = `LBDR_Z_W'(id / NODES_PER_LAYER);
    return c;
  endfunction

  // own position, fixed at elaboration
  localparam coord_t OWN_C = id_to_coord(node_id_t'(NODE_ID));

  coord_t     dest_c;
  dir_flags_t flags_d;
  dir_flags_t flags_q;
  logic       valid_q;

  assign dest_c = id_to_coord(req_dest_i);

  // strict comparisons, own node gives all zero
  assign flags_d.n = dest_c.y > OWN_C.y;
  assign flags_d.s = dest_c.y < OWN_C.y;
  assign flags_d.e = dest_c.x > OWN_C.x;
  assign flags_d.w = dest_c.x < OWN_C.x;
  assign flags_d.u = dest_c.z > OWN_C.z;
  assign flags_d.d = dest_c.z < OWN_C.z;

  // ------------------------------------------------
  // pipeline register
  // accept when empty or when the content leaves now
  assign req_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  // payload only moves on a handshake
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      flags_q <= flags_d;
    end
  end

  assign out_valid_o = valid_q;
  assign out_flags_o = flags_q;

endmodule

/* source/lbdr_rule_eval.sv */
// ------------------------------------------------
// processing part of the lbdr stage: evaluates the
// turn rules per port and registers the candidate
// mask before connectivity is applied
// ------------------------------------------------

`timescale 1ns/100ps

module lbdr_rule_eval
  import noc_geom_pkg::*, lbdr_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  // flags from the decode side
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  dir_flags_t in_flags_i,
  // routing and turn bits
  input  lbdr_cfg_t  cfg_i,
  // candidate mask toward the output side
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output port_mask_t out_mask_o
);

  // ------------------------------------------------
  // one rule for every port p on axis a
  //   p must point toward the destination
  //   no offset on the other axes, straight on
  //   one other axis with offset q, needs R_pq
  //   both other axes offset, needs both turns into a
  //   and R toward at least one of them
  // b1/b2 carry {positive, negative} flags of the other axes
  // r1/r2 carry the matching R bits in the same order
  function automatic logic port_rule(
    input logic       p,
    input logic [1:0] b1,
    input logic [1:0] b2,
    input logic [1:0] r1,
    input logic [1:0] r2,
    input logic       t1,
    input logic       t2
  );
    logic off1;
    logic off2;
    logic r_ok;
    logic none;
    logic one;
    logic two;
    off1 = |b1;
    off2 = |b2;
    // R bit toward the direction actually pending
    r_ok = |(b1 & r1) || |(b2 & r2);
    none = !off1 && !off2;
    one  = (off1 ^ off2) && r_ok;
    two  = off1 && off2 && t1 && t2 && r_ok;
    return p && (none || one || two);
  endfunction

  dir_flags_t f;
  port_mask_t cand_d;
  port_mask_t mask_q;
  logic       valid_q;

  assign f = in_flags_i;

  // y axis ports, other axes x and z
  assign cand_d[PORT_N] = port_rule(f.n, {f.e, f.w}, {f.u, f.d},
                                    {cfg_i.r[RNE], cfg_i.r[RNW]},
                                    {cfg_i.r[RNU], cfg_i.r[RND]},
                                    cfg_i.t.txy, cfg_i.t.tzy);
  assign cand_d[PORT_S] = port_rule(f.s, {f.e, f.w}, {f.u, f.d},
                                    {cfg_i.r[RSE], cfg_i.r[RSW]},
                                    {cfg_i.r[RSU], cfg_i.r[RSD]},
                                    cfg_i.t.txy, cfg_i.t.tzy);

  // x axis ports, other axes y and z
  assign cand_d[PORT_E] = port_rule(f.e, {f.n, f.s}, {f.u, f.d},
                                    {cfg_i.r[REN], cfg_i.r[RES]},
                                    {cfg_i.r[REU], cfg_i.r[RED]},
                                    cfg_i.t.tyx, cfg_i.t.tzx);
  assign cand_d[PORT_W] = port_rule(f.w, {f.n, f.s}, {f.u, f.d},
                                    {cfg_i.r[RWN], cfg_i.r[RWS]},
                                    {cfg_i.r[RWU], cfg_i.r[RWD]},
                                    cfg_i.t.tyx, cfg_i.t.tzx);

  // z axis ports, other axes x and y
  assign cand_d[PORT_U] = port_rule(f.u, {f.e, f.w}, {f.n, f.s},
                                    {cfg_i.r[RUE], cfg_i.r[RUW]},
                                    {cfg_i.r[RUN], cfg_i.r[RUS]},
                                    cfg_i.t.txz, cfg_i.t.tyz);
  assign cand_d[PORT_D] = port_rule(f.d, {f.e, f.w}, {f.n, f.s},
                                    {cfg_i.r[RDE], cfg_i.r[RDW]},
                                    {cfg_i.r[RDN], cfg_i.r[RDS]},
                                    cfg_i.t.txz, cfg_i.t.tyz);

  // ------------------------------------------------
  // pipeline register
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      mask_q <= cand_d;
    end
  end

  assign out_valid_o = valid_q;
  assign out_mask_o  = mask_q;

endmodule

/* source/lbdr_port_mask.sv */
// ------------------------------------------------
// output side of the lbdr stage: drops ports with
// no neighbour and holds the mask for the consumer
// ------------------------------------------------

`timescale 1ns/100ps

module lbdr_port_mask
  import lbdr_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  // candidate mask from rule evaluation
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  port_mask_t in_mask_i,
  // connectivity bits of this node
  input  lbdr_cfg_t  cfg_i,
  // response toward the consumer
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output port_mask_t rsp_mask_o
);

  port_mask_t mask_d;
  port_mask_t mask_q;
  logic       valid_q;

  // a port is only usable when a switch sits behind it
  assign mask_d = in_mask_i & cfg_i.c;

  // ------------------------------------------------
  // output register
  // result stays put while the consumer stalls
  assign in_ready_o = !valid_q || rsp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      mask_q <= mask_d;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_mask_o  = mask_q;

endmodule

/* source/lbdr_route_3d.sv */
// ------------------------------------------------
// lbdr routing stage of a 3d mesh router
// decode, rule evaluation and port mask in a
// three deep valid/ready pipeline
// ------------------------------------------------

`timescale 1ns/100ps

module lbdr_route_3d
  import noc_geom_pkg::*, lbdr_pkg::*;
#(
  // default node sits at x=2, y=1, z=1
  parameter int unsigned NODE_ID = 27
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  // request
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  node_id_t   req_dest_i,
  // routing table, stable while requests are in flight
  input  lbdr_cfg_t  cfg_i,
  // response
  output logic       rsp_valid_o,
  input  logic       rsp_ready_i,
  output port_mask_t rsp_mask_o
);

  // decode to eval
  logic       dec_valid;
  logic       dec_ready;
  dir_flags_t dec_flags;

  // eval to mask
  logic       ev_valid;
  logic       ev_ready;
  port_mask_t ev_mask;

  lbdr_dest_decode #(
    .NODE_ID(NODE_ID)
  ) u_decode (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_dest_i  (req_dest_i),
    .out_valid_o (dec_valid),
    .out_ready_i (dec_ready),
    .out_flags_o (dec_flags)
  );

  lbdr_rule_eval u_eval (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (dec_valid),
    .in_ready_o  (dec_ready),
    .in_flags_i  (dec_flags),
    .cfg_i       (cfg_i),
    .out_valid_o (ev_valid),
    .out_ready_i (ev_ready),
    .out_mask_o  (ev_mask)
  );

  lbdr_port_mask u_mask (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (ev_valid),
    .in_ready_o  (ev_ready),
    .in_mask_i   (ev_mask),
    .cfg_i       (cfg_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_mask_o  (rsp_mask_o)
  );

endmodule

/* verif/lbdr_ref_model.svh */
// ------------------------------------------------
// reference model of the lbdr stage: coordinates,
// direction flags, per-port rule and final mask
// ------------------------------------------------

`ifndef LBDR_REF_MODEL_SVH
`define LBDR_REF_MODEL_SVH

`include "lbdr_consts.svh"

  // column first, then row, then layer
  function automatic coord_t coord_of(input int id);
    coord_t c;
    c.x = `LBDR_X_W'(id % `LBDR_NUM_COLS);
    c.y = `LBDR_Y_W'((id / `LBDR_NUM_COLS) % `LBDR_NUM_ROWS);
    c.z = `LBDR_Z_W'(id / (`LBDR_NUM_COLS * `LBDR_NUM_ROWS));
    return c;
  endfunction

  // one flag per port, set when the destination lies strictly that way
  function automatic logic [5:0] flags_toward(input coord_t own, input coord_t dst);
    logic [5:0] f;
    f[PORT_N] = dst.y > own.y;
    f[PORT_S] = dst.y < own.y;
    f[PORT_E] = dst.x > own.x;
    f[PORT_W] = dst.x < own.x;
    f[PORT_U] = dst.z > own.z;
    f[PORT_D] = dst.z < own.z;
    return f;
  endfunction

  // axis codes: z=0, y=1, x=2
  function automatic int axis_of(input int p);
    if (p == PORT_N || p == PORT_S) return 1;
    if (p == PORT_E || p == PORT_W) return 2;
    return 0;
  endfunction

  function automatic logic is_positive(input int q);
    return q == PORT_N || q == PORT_E || q == PORT_U;
  endfunction

  // four R bits per port starting at 4*p
  // lower pair belongs to the lower other axis (z below y below x)
  // negative direction sits below positive inside a pair
  function automatic int rbit_index(input int p, input int q);
    int a;
    int b;
    int rest;
    a = axis_of(p);
    b = axis_of(q);
    rest = 3 - a - b;
    return 4 * p + 2 * int'(b > rest) + int'(is_positive(q));
  endfunction

  function automatic logic port_allowed(input int p, input logic [5:0] f,
                                        input lbdr_cfg_t cfg);
    int         n_off;
    int         q;
    logic       r_any;
    logic [5:0] t;
    n_off = 0;
    r_any = 1'b0;
    t = cfg.t;
    // at most one flag per axis, so each offset axis counts once
    for (q = 0; q < 6; q++) begin
      if (axis_of(q) != axis_of(p) && f[q]) begin
        n_off++;
        r_any = r_any | cfg.r[rbit_index(p, q)];
      end
    end
    if (!f[p]) return 1'b0;
    if (n_off == 0) return 1'b1;
    if (n_off == 1) return r_any;
    // both turns into this axis, pair sits at bits 2a+1 and 2a
    return r_any && t[2 * axis_of(p) + 1] && t[2 * axis_of(p)];
  endfunction

  function automatic port_mask_t expected_mask(input int own_id, input int dest,
                                               input lbdr_cfg_t cfg);
    logic [5:0] f;
    port_mask_t m;
    int         p;
    f = flags_toward(coord_of(own_id), coord_of(dest));
    for (p = 0; p < 6; p++) begin
      m[p] = port_allowed(p, f, cfg) && cfg.c[p];
    end
    return m;
  endfunction

`endif

/* verif/tb_lbdr_route_3d.sv */
// ------------------------------------------------
// testbench for the lbdr routing stage: random
// requests checked through a scoreboard queue
// ------------------------------------------------

`timescale 1ns/100ps
`include "lbdr_consts.svh"

module tb_lbdr_route_3d
  import noc_geom_pkg::*, lbdr_pkg::*;
();

  localparam int OWN_NODE       = 27;
  localparam int TIMEOUT_CYCLES = 200;
  localparam int NUM_NODES      = `LBDR_NUM_COLS * `LBDR_NUM_ROWS * `LBDR_NUM_LAYERS;

  `include "lbdr_ref_model.svh"

  logic       clk;
  logic       arst_n;
  logic       req_valid;
  logic       req_ready;
  node_id_t   req_dest;
  lbdr_cfg_t  cfg;
  logic       rsp_valid;
  logic       rsp_ready;
  port_mask_t rsp_mask;

  // expected masks in acceptance order
  port_mask_t exp_q[$];
  port_mask_t exp_mask;
  string      test_name;
  int         seed;
  int         checks;
  int         errors;
  logic       toggle_ready;

  lbdr_route_3d #(
    .NODE_ID(OWN_NODE)
  ) dut0 (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_dest_i  (req_dest),
    .cfg_i       (cfg),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_mask_o  (rsp_mask)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------
  // scoreboard sampled at the falling edge
  // a handshake seen here completes at the next rising edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (rsp_valid && rsp_ready) begin
        checks++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR %s: response with no request pending", test_name);
        end else begin
          exp_mask = exp_q.pop_front();
          if (rsp_mask !== exp_mask) begin
            errors++;
            $display("MISMATCH %s: expected %b, actual %b", test_name, exp_mask, rsp_mask);
          end
        end
      end
      if (req_valid && req_ready) begin
        exp_q.push_back(expected_mask(OWN_NODE, req_dest, cfg));
      end
    end
  end

  // ------------------------------------------------
  // stimulus helpers
  function automatic lbdr_cfg_t random_cfg(input logic all_links);
    lbdr_cfg_t c;
    c.r = `LBDR_NUM_RBITS'($random(seed));
    c.t = `LBDR_NUM_TBITS'($random(seed));
    c.c = all_links ? '1 : `LBDR_NUM_CBITS'($random(seed));
    return c;
  endfunction

  // any value below n except own
  function automatic int other_value(input int n, input int own);
    int v;
    v = int'($unsigned($random(seed)) % (n - 1));
    if (v >= own) v++;
    return v;
  endfunction

  // destination offset on the given number of axes
  // a negative count picks any node
  function automatic node_id_t pick_dest(input int offsets);
    coord_t     own;
    int         pick;
    int         k;
    logic [2:0] mv;
    int         x;
    int         y;
    int         z;
    own = coord_of(OWN_NODE);
    if (offsets < 0) return node_id_t'($unsigned($random(seed)) % NUM_NODES);
    // pick is the only moved axis for one offset and the fixed one for two
    pick = int'($unsigned($random(seed)) % 3);
    for (k = 0; k < 3; k++) begin
      mv[k] = (offsets == 3) || (offsets == 2 && k != pick) || (offsets == 1 && k == pick);
    end
    x = mv[2] ? other_value(`LBDR_NUM_COLS, int'(own.x)) : int'(own.x);
    y = mv[1] ? other_value(`LBDR_NUM_ROWS, int'(own.y)) : int'(own.y);
    z = mv[0] ? other_value(`LBDR_NUM_LAYERS, int'(own.z)) : int'(own.z);
    return node_id_t'(z * `LBDR_NUM_COLS * `LBDR_NUM_ROWS + y * `LBDR_NUM_COLS + x);
  endfunction

  // hold the request until accepted
  // entered 0.5 ns after a rising edge
  task automatic send_req(input node_id_t dest);
    int   waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    req_valid = 1'b1;
    req_dest = dest;
    while (!taken && waited < TIMEOUT_CYCLES) begin
      if (toggle_ready) rsp_ready = ($random(seed) & 1) != 0;
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
      #0.5;
      waited++;
    end
    req_valid = 1'b0;
    if (!taken) begin
      errors++;
      $display("ERROR %s: request for node %0d not accepted in time", test_name, dest);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #0.5;
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR %s: %0d responses never arrived", test_name, exp_q.size());
      exp_q.delete();
    end
  endtask

  // three requests fill the pipeline while the consumer stalls
  task automatic fill_stalled();
    int chk0;
    int err0;
    int i;
    chk0 = checks;
    err0 = errors;
    test_name = "fill_stall";
    cfg = random_cfg(1'b0);
    for (i = 0; i < 3; i++) begin
      send_req(pick_dest(-1));
    end
    @(negedge clk);
    checks++;
    if (req_ready !== 1'b0 || rsp_valid !== 1'b1) begin
      errors++;
      $display("MISMATCH %s: expected ready 0 valid 1, actual ready %b valid %b",
               test_name, req_ready, rsp_valid);
    end
    @(posedge clk);
    #0.5;
    rsp_ready = 1'b1;
    drain();
    $display("test %s done: %0d checks, %0d errors", test_name, checks - chk0, errors - err0);
  endtask

  // cfg only changes once every response of the group is back
  task automatic run_test(input string name, input int offsets, input int groups,
                          input int per_group, input logic random_ready);
    int chk0;
    int err0;
    int g;
    int i;
    chk0 = checks;
    err0 = errors;
    test_name = name;
    for (g = 0; g < groups; g++) begin
      cfg = random_cfg(offsets == 2 || offsets == 3);
      toggle_ready = random_ready;
      for (i = 0; i < per_group; i++) begin
        send_req(pick_dest(offsets));
      end
      toggle_ready = 1'b0;
      rsp_ready = 1'b1;
      drain();
    end
    $display("test %s done: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // ------------------------------------------------
  // main sequence
  initial begin
    seed = 32'h405e_ed83;
    arst_n = 1'b0;
    req_valid = 1'b0;
    req_dest = '0;
    cfg = '0;
    // consumer stalled so request ready depends on every valid bit
    rsp_ready = 1'b0;
    toggle_ready = 1'b0;
    checks = 0;
    errors = 0;
    test_name = "reset";
    repeat (5) @(posedge clk);
    #0.5;
    arst_n = 1'b1;
    if (req_ready !== 1'b1 || rsp_valid !== 1'b0) begin
      errors++;
      $display("MISMATCH reset: expected ready 1 valid 0, actual ready %b valid %b",
               req_ready, rsp_valid);
    end
    fill_stalled();
    run_test("single_axis", 1, 6, 8, 1'b0);
    run_test("own_node", 0, 4, 4, 1'b0);
    run_test("two_axis", 2, 6, 8, 1'b0);
    run_test("three_axis", 3, 6, 8, 1'b0);
    run_test("random_stream", -1, 6, 50, 1'b1);
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* lbdr_route_3d.f */
+incdir+source
+incdir+verif
source/noc_geom_pkg.sv
source/lbdr_pkg.sv
source/lbdr_dest_decode.sv
source/lbdr_rule_eval.sv
source/lbdr_port_mask.sv
source/lbdr_route_3d.sv
verif/tb_lbdr_route_3d.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the lbdr routing stage testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f lbdr_route_3d.f \
  --top-module tb_lbdr_route_3d \
  -o tb_lbdr_route_3d

sim_out=$(./obj_dir/tb_lbdr_route_3d)
echo "$sim_out"

# the verdict line of the testbench decides the exit status
if grep -q "=== PASS ===" <<< "$sim_out"; then
  exit 0
fi
exit 1
